//--- Makefile
# Verilator simulation of the vertex job front end

TOP := cu_vertex_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f accel_graph_vertex.f \
		-Mdir obj_dir -o $(TOP)

# Pass only if the log holds the pass line
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- accel_graph_vertex.f
hw/graph_cu_pkg.sv
hw/fifo.sv
hw/cu_vertex_job_generator.sv
hw/cu_vertex_job_filter.sv
hw/cu_vertex_job_tracker.sv
hw/cu_vertex_control.sv
verification/tb_clock_gen.sv
verification/cu_vertex_tb.sv

//--- hw/cu_vertex_control.sv
`timescale 1ns/100ps
`default_nettype none

module cu_vertex_control #(
	parameter int TABLE_DEPTH      = graph_cu_pkg::TABLE_DEPTH_DEFAULT,
	parameter int JOB_BUFFER_DEPTH = graph_cu_pkg::JOB_BUFFER_DEPTH_DEFAULT
) (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    table_write,
	input  logic [graph_cu_pkg::VERTEX_ID_BITS-1:0] table_addr,
	input  logic [graph_cu_pkg::DEGREE_BITS-1:0]    table_degree,
	input  logic                                    start,
	input  logic [graph_cu_pkg::VERTEX_ID_BITS-1:0] range_first,
	input  logic [graph_cu_pkg::VERTEX_ID_BITS-1:0] range_count,
	input  logic                                    enabled,
	input  logic                                    vertex_request,
	output logic                                    vertex_out_valid,
	output logic [graph_cu_pkg::VERTEX_ID_BITS-1:0] vertex_out_id,
	output logic [graph_cu_pkg::DEGREE_BITS-1:0]    vertex_out_degree,
	output logic [graph_cu_pkg::VERTEX_ID_BITS-1:0] filtered_count,
	output logic                                    done
);

	import graph_cu_pkg::*;

	// Generator to filter
	logic                      vertex_in_valid;
	logic [VERTEX_ID_BITS-1:0] vertex_in_id;
	logic [DEGREE_BITS-1:0]    vertex_in_degree;
	logic                      vertex_request_unfiltered;

	////////////////////////////////////////////////////////////
	// Job generator
	////////////////////////////////////////////////////////////

	cu_vertex_job_generator #(
		.TABLE_DEPTH(TABLE_DEPTH)
	) u_generator (
		.clock                    (clock),
		.rstn                     (rstn),
		.table_write              (table_write),
		.table_addr               (table_addr),
		.table_degree             (table_degree),
		.start                    (start),
		.range_first              (range_first),
		.range_count              (range_count),
		.vertex_request_unfiltered(vertex_request_unfiltered),
		.vertex_in_valid          (vertex_in_valid),
		.vertex_in_id             (vertex_in_id),
		.vertex_in_degree         (vertex_in_degree)
	);

	////////////////////////////////////////////////////////////
	// Zero-degree filter and job buffer
	////////////////////////////////////////////////////////////

	cu_vertex_job_filter #(
		.JOB_BUFFER_DEPTH(JOB_BUFFER_DEPTH)
	) u_filter (
		.clock                      (clock),
		.rstn                       (rstn),
		.enabled_in                 (enabled),
		.vertex_in_valid            (vertex_in_valid),
		.vertex_in_id               (vertex_in_id),
		.vertex_in_degree           (vertex_in_degree),
		.vertex_request_filtered    (vertex_request),
		.vertex_request_unfiltered  (vertex_request_unfiltered),
		.vertex_out_valid           (vertex_out_valid),
		.vertex_out_id              (vertex_out_id),
		.vertex_out_degree          (vertex_out_degree),
		.vertex_job_counter_filtered(filtered_count)
	);

	// Completion, watches the filter outputs
	cu_vertex_job_tracker u_tracker (
		.clock                      (clock),
		.rstn                       (rstn),
		.start                      (start),
		.range_count                (range_count),
		.vertex_out_valid           (vertex_out_valid),
		.vertex_job_counter_filtered(filtered_count),
		.done                       (done)
	);

endmodule

`default_nettype wire

//--- hw/cu_vertex_job_filter.sv
`timescale 1ns/100ps
`default_nettype none

module cu_vertex_job_filter #(
	parameter int JOB_BUFFER_DEPTH = graph_cu_pkg::JOB_BUFFER_DEPTH_DEFAULT
) (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    enabled_in,
	input  logic                                    vertex_in_valid,
	input  logic [graph_cu_pkg::VERTEX_ID_BITS-1:0] vertex_in_id,
	input  logic [graph_cu_pkg::DEGREE_BITS-1:0]    vertex_in_degree,
	input  logic                                    vertex_request_filtered,
	output logic                                    vertex_request_unfiltered,
	output logic                                    vertex_out_valid,
	output logic [graph_cu_pkg::VERTEX_ID_BITS-1:0] vertex_out_id,
	output logic [graph_cu_pkg::DEGREE_BITS-1:0]    vertex_out_degree,
	output logic [graph_cu_pkg::VERTEX_ID_BITS-1:0] vertex_job_counter_filtered
);

	import graph_cu_pkg::*;

	localparam int JOB_BITS = VERTEX_ID_BITS + DEGREE_BITS;

	logic                      enabled;
	logic                      vertex_in_valid_latched;
	logic [VERTEX_ID_BITS-1:0] vertex_in_id_latched;
	logic [DEGREE_BITS-1:0]    vertex_in_degree_latched;
	logic                      vertex_request_filtered_latched;
	logic                      request_unfiltered_q;
	logic [VERTEX_ID_BITS-1:0] counter_filtered_latched;
	logic                      filter_vertex;
	logic                      push_vertex;
	logic                      pop_vertex;
	logic                      buffer_almost_full;
	logic                      buffer_empty;
	logic                      buffer_valid;
	logic [JOB_BITS-1:0]       buffer_data;

	////////////////////////////////////////////////////////////
	// Enable and input registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled                         <= 1'b0;
			vertex_in_valid_latched         <= 1'b0;
			vertex_request_filtered_latched <= 1'b0;
		end else begin
			enabled <= enabled_in;
			if (enabled) begin
				vertex_in_valid_latched         <= vertex_in_valid;
				vertex_request_filtered_latched <= vertex_request_filtered;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enabled) begin
			vertex_in_id_latched     <= vertex_in_id;
			vertex_in_degree_latched <= vertex_in_degree;
		end
	end

	////////////////////////////////////////////////////////////
	// Classify, count and buffer
	////////////////////////////////////////////////////////////

	// Held input is acted on once, in the first enabled cycle
	assign filter_vertex = enabled && vertex_in_valid_latched && ~(|vertex_in_degree_latched);
	assign push_vertex   = enabled && vertex_in_valid_latched && (|vertex_in_degree_latched);
	// Pop only if the read strobe lands in an enabled cycle
	assign pop_vertex    = enabled && enabled_in && vertex_request_filtered_latched
		&& !buffer_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			counter_filtered_latched <= '0;
		end else if (filter_vertex) begin
			counter_filtered_latched <= counter_filtered_latched + 1'b1;
		end
	end

	fifo #(
		.WIDTH(JOB_BITS),
		.DEPTH(JOB_BUFFER_DEPTH)
	) vertex_job_buffer (
		.clock      (clock),
		.rstn       (rstn),
		.push       (push_vertex),
		.data_in    ({vertex_in_id_latched, vertex_in_degree_latched}),
		.full       (),
		.almost_full(buffer_almost_full),
		.pop        (pop_vertex),
		.valid      (buffer_valid),
		.data_out   (buffer_data),
		.empty      (buffer_empty)
	);

	////////////////////////////////////////////////////////////
	// Output registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_out_valid            <= 1'b0;
			request_unfiltered_q        <= 1'b0;
			vertex_job_counter_filtered <= '0;
		end else if (enabled) begin
			vertex_out_valid            <= buffer_valid;
			request_unfiltered_q        <= ~buffer_almost_full;
			vertex_job_counter_filtered <= counter_filtered_latched;
		end else begin
			// Strobe, so no repeat while held
			vertex_out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (enabled && buffer_valid) begin
			{vertex_out_id, vertex_out_degree} <= buffer_data;
		end
	end

	// Generator stalls as soon as the enable drops
	assign vertex_request_unfiltered = request_unfiltered_q && enabled_in;

endmodule

`default_nettype wire

//--- hw/cu_vertex_job_generator.sv
`timescale 1ns/100ps
`default_nettype none

module cu_vertex_job_generator #(
	parameter int TABLE_DEPTH = graph_cu_pkg::TABLE_DEPTH_DEFAULT
) (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    table_write,
	input  logic [graph_cu_pkg::VERTEX_ID_BITS-1:0] table_addr,
	input  logic [graph_cu_pkg::DEGREE_BITS-1:0]    table_degree,
	input  logic                                    start,
	input  logic [graph_cu_pkg::VERTEX_ID_BITS-1:0] range_first,
	input  logic [graph_cu_pkg::VERTEX_ID_BITS-1:0] range_count,
	input  logic                                    vertex_request_unfiltered,
	output logic                                    vertex_in_valid,
	output logic [graph_cu_pkg::VERTEX_ID_BITS-1:0] vertex_in_id,
	output logic [graph_cu_pkg::DEGREE_BITS-1:0]    vertex_in_degree
);

	import graph_cu_pkg::*;

	localparam int ADDR_BITS = $clog2(TABLE_DEPTH);

	// Inverse out-degree per vertex, host loaded
	logic [DEGREE_BITS-1:0]    degree_table [TABLE_DEPTH];
	gen_state_t                state;
	logic [VERTEX_ID_BITS-1:0] next_id;
	logic [VERTEX_ID_BITS-1:0] remaining;
	logic                      issue;

	// One table read per requested cycle while running
	assign issue = (state == GEN_RUN) && vertex_request_unfiltered;

	////////////////////////////////////////////////////////////
	// Host table writes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (table_write) begin
			degree_table[table_addr[ADDR_BITS-1:0]] <= table_degree;
		end
	end

	////////////////////////////////////////////////////////////
	// Range walker FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= GEN_IDLE;
			next_id   <= '0;
			remaining <= '0;
		end else begin
			case (state)
				GEN_IDLE: begin
					// Latch the range on start
					if (start) begin
						next_id   <= range_first;
						remaining <= range_count;
						state     <= (range_count == '0) ? GEN_DONE : GEN_RUN;
					end
				end
				GEN_RUN: begin
					if (issue) begin
						next_id   <= next_id + 1'b1;
						remaining <= remaining - 1'b1;
						// Last index issued
						if (remaining == VERTEX_ID_BITS'(1)) begin
							state <= GEN_DONE;
						end
					end
				end
				GEN_DONE: state <= GEN_IDLE;
				default:  state <= GEN_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Job output, one cycle after the read
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_in_valid <= 1'b0;
		end else begin
			vertex_in_valid <= issue;
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			vertex_in_id     <= next_id;
			vertex_in_degree <= degree_table[next_id[ADDR_BITS-1:0]];
		end
	end

endmodule

`default_nettype wire

//--- hw/cu_vertex_job_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module cu_vertex_job_tracker (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    start,
	input  logic [graph_cu_pkg::VERTEX_ID_BITS-1:0] range_count,
	input  logic                                    vertex_out_valid,
	input  logic [graph_cu_pkg::VERTEX_ID_BITS-1:0] vertex_job_counter_filtered,
	output logic                                    done
);

	import graph_cu_pkg::*;

	logic                      armed;
	logic [VERTEX_ID_BITS-1:0] forwarded_count;
	logic [VERTEX_ID_BITS-1:0] filtered_base;
	logic [VERTEX_ID_BITS-1:0] target_count;
	logic [VERTEX_ID_BITS-1:0] job_total;

	// Filter counter runs across runs, take the delta since start
	assign job_total = forwarded_count + (vertex_job_counter_filtered - filtered_base);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			armed           <= 1'b0;
			forwarded_count <= '0;
			filtered_base   <= '0;
			target_count    <= '0;
			done            <= 1'b0;
		end else if (start) begin
			armed           <= 1'b1;
			forwarded_count <= '0;
			filtered_base   <= vertex_job_counter_filtered;
			target_count    <= range_count;
			done            <= 1'b0;
		end else begin
			if (vertex_out_valid) begin
				forwarded_count <= forwarded_count + 1'b1;
			end
			// Sticky until the next start
			if (armed && (job_total == target_count)) begin
				done <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/fifo.sv
`timescale 1ns/100ps
`default_nettype none

module fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	output logic             full,
	output logic             almost_full,
	input  logic             pop,
	output logic             valid,
	output logic [WIDTH-1:0] data_out,
	output logic             empty
);

	localparam int ADDR_BITS = $clog2(DEPTH);
	localparam int CNT_BITS  = ADDR_BITS + 1;
	localparam logic [ADDR_BITS-1:0] LAST_ADDR  = ADDR_BITS'(DEPTH - 1);
	localparam logic [CNT_BITS-1:0]  FULL_LEVEL = CNT_BITS'(DEPTH);
	// Margin of 4 covers the request, input and push stages upstream
	localparam logic [CNT_BITS-1:0]  ALFULL_LEVEL = CNT_BITS'(DEPTH - 4);

	logic [WIDTH-1:0]     mem [DEPTH];
	logic [ADDR_BITS-1:0] wr_ptr;
	logic [ADDR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0]  count;
	logic                 do_push;
	logic                 do_pop;

	// Status from occupancy
	assign full        = (count == FULL_LEVEL);
	assign almost_full = (count >= ALFULL_LEVEL);
	assign empty       = (count == '0);

	// Overflow and underflow are ignored
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop keep the count
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
			// Read strobe one cycle after the pop
			valid <= do_pop;
		end
	end

	////////////////////////////////////////////////////////////
	// Storage and registered read
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
		if (do_pop) begin
			data_out <= mem[rd_ptr];
		end
	end

endmodule

`default_nettype wire

//--- hw/graph_cu_pkg.sv
`default_nettype none

package graph_cu_pkg;

	////////////////////////////////////////////////////////////
	// Vertex job widths
	////////////////////////////////////////////////////////////

	// Vertex index, also used for counts over a range
	localparam int VERTEX_ID_BITS = 16;

	// Inverse out-degree, zero means no out-edges
	localparam int DEGREE_BITS = 16;

	////////////////////////////////////////////////////////////
	// Default sizes
	////////////////////////////////////////////////////////////

	// Filtered job buffer entries
	localparam int JOB_BUFFER_DEPTH_DEFAULT = 16;

	// Degree table entries loaded by the host
	localparam int TABLE_DEPTH_DEFAULT = 64;

	////////////////////////////////////////////////////////////
	// Generator FSM
	////////////////////////////////////////////////////////////

	// Idle waits for start, run walks the range,
	// done lasts one cycle before idle again
	typedef enum logic [1:0] {
		GEN_IDLE = 2'b00,
		GEN_RUN  = 2'b01,
		GEN_DONE = 2'b10
	} gen_state_t;

endpackage

`default_nettype wire

//--- verification/cu_vertex_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cu_vertex_tb;

	import graph_cu_pkg::*;

	localparam int NUM_TESTS     = 7;
	localparam int SETTLE_CYCLES = 6;

	////////////////////////////////////////////////////////////
	// Stimulus table, one row per test
	////////////////////////////////////////////////////////////

	// Range, zero-degree percentage, request gaps, enable toggling
	int row_first  [NUM_TESTS] = '{0, 5, 0, 10, 30, 0, 8};
	int row_count  [NUM_TESTS] = '{20, 40, 64, 16, 34, 48, 50};
	int row_zero   [NUM_TESTS] = '{25, 50, 30, 100, 0, 25, 40};
	bit row_gaps   [NUM_TESTS] = '{0, 1, 1, 0, 1, 0, 1};
	bit row_toggle [NUM_TESTS] = '{0, 0, 0, 0, 1, 1, 1};

	logic                      clock;
	logic                      rstn;
	logic                      table_write;
	logic [VERTEX_ID_BITS-1:0] table_addr;
	logic [DEGREE_BITS-1:0]    table_degree;
	logic                      start;
	logic [VERTEX_ID_BITS-1:0] range_first;
	logic [VERTEX_ID_BITS-1:0] range_count;
	logic                      enabled;
	logic                      vertex_request;
	logic                      vertex_out_valid;
	logic [VERTEX_ID_BITS-1:0] vertex_out_id;
	logic [DEGREE_BITS-1:0]    vertex_out_degree;
	logic [VERTEX_ID_BITS-1:0] filtered_count;
	logic                      done;
	gen_state_t                gen_state;

	// Software model of the table and the expected job stream
	logic [DEGREE_BITS-1:0]    model_degree [TABLE_DEPTH_DEFAULT];
	int                        expected_ids [$];
	int                        expected_filtered;
	int                        forwarded;
	bit                        done_prev;
	logic                      enabled_prev;
	logic [VERTEX_ID_BITS-1:0] filtered_prev;
	int                        errors;
	int                        failed_tests;
	int                        cycle_count;
	int                        cycle_limit;

	tb_clock_gen u_clock_gen (
		.clock(clock),
		.rstn (rstn)
	);

	cu_vertex_control #(
		.TABLE_DEPTH     (TABLE_DEPTH_DEFAULT),
		.JOB_BUFFER_DEPTH(JOB_BUFFER_DEPTH_DEFAULT)
	) u_cu_vertex_control (
		.clock            (clock),
		.rstn             (rstn),
		.table_write      (table_write),
		.table_addr       (table_addr),
		.table_degree     (table_degree),
		.start            (start),
		.range_first      (range_first),
		.range_count      (range_count),
		.enabled          (enabled),
		.vertex_request   (vertex_request),
		.vertex_out_valid (vertex_out_valid),
		.vertex_out_id    (vertex_out_id),
		.vertex_out_degree(vertex_out_degree),
		.filtered_count   (filtered_count),
		.done             (done)
	);

	// Generator FSM, for the timeout message
	assign gen_state = u_cu_vertex_control.u_generator.state;

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("ERROR t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
		errors++;
	endtask

	////////////////////////////////////////////////////////////
	// Output monitor, sampled on the falling edge
	////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		int exp_id;
		if (rstn) begin
			if (vertex_out_valid) begin
				assert (expected_ids.size() > 0) else begin
					$display("Extra job with id %0d forwarded at %0t", vertex_out_id, $time);
					errors++;
				end
				assert (vertex_out_degree != '0) else begin
					$display("Zero-degree vertex %0d forwarded at %0t", vertex_out_id, $time);
					errors++;
				end
				if (expected_ids.size() > 0) begin
					exp_id = expected_ids.pop_front();
					assert (vertex_out_id == VERTEX_ID_BITS'(exp_id)) else
						report_mismatch("vertex_out_id", exp_id, int'(vertex_out_id));
					assert (vertex_out_degree == model_degree[exp_id]) else
						report_mismatch("vertex_out_degree", int'(model_degree[exp_id]),
							int'(vertex_out_degree));
					forwarded++;
				end
			end
			// Filter registers frozen one cycle after the enable drops
			if (!enabled_prev) begin
				assert (!vertex_out_valid) else begin
					$display("Job forwarded at %0t while the filter was disabled", $time);
					errors++;
				end
				assert (filtered_count == filtered_prev) else
					report_mismatch("filtered_count", int'(filtered_prev), int'(filtered_count));
			end
			// Done must come after the last job
			if (done && !done_prev) begin
				assert (expected_ids.size() == 0) else begin
					$display("Done raised at %0t with %0d jobs still missing", $time,
						expected_ids.size());
					errors++;
				end
				assert (filtered_count == VERTEX_ID_BITS'(expected_filtered)) else
					report_mismatch("filtered_count", expected_filtered, int'(filtered_count));
			end
		end
		done_prev     = done;
		enabled_prev  = enabled;
		filtered_prev = filtered_count;
	end

	// Hang guard over the whole run
	always @(negedge clock) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("Timeout after %0d cycles, generator in %s", cycle_limit, gen_state.name());
			$display("Some tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////

	// Host writes over the range, model built alongside
	task automatic load_table(input int t);
		logic [DEGREE_BITS-1:0] degree;
		for (int i = row_first[t]; i < row_first[t] + row_count[t]; i++) begin
			if (($urandom % 100) < row_zero[t]) begin
				degree = '0;
				expected_filtered++;
			end else begin
				degree = DEGREE_BITS'(($urandom % 65535) + 1);
				expected_ids.push_back(i);
			end
			model_degree[i] = degree;
			@(negedge clock);
			table_write  <= 1'b1;
			table_addr   <= VERTEX_ID_BITS'(i);
			table_degree <= degree;
		end
		@(negedge clock);
		table_write <= 1'b0;
	endtask

	task automatic pulse_start(input int t);
		@(negedge clock);
		start          <= 1'b1;
		range_first    <= VERTEX_ID_BITS'(row_first[t]);
		range_count    <= VERTEX_ID_BITS'(row_count[t]);
		vertex_request <= 1'b1;
		@(negedge clock);
		start <= 1'b0;
	endtask

	task automatic check_reset_state();
		assert (!vertex_out_valid) else report_mismatch("vertex_out_valid", 0, 1);
		assert (!done) else report_mismatch("done", 0, 1);
		assert (filtered_count == '0) else
			report_mismatch("filtered_count", 0, int'(filtered_count));
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int test_errors;
		int filtered_base;
		int run_cycle;
		int total;
		void'($urandom(52116));
		table_write       = 1'b0;
		table_addr        = '0;
		table_degree      = '0;
		start             = 1'b0;
		range_first       = '0;
		range_count       = '0;
		enabled           = 1'b1;
		vertex_request    = 1'b0;
		expected_filtered = 0;
		forwarded         = 0;
		errors            = 0;
		failed_tests      = 0;
		cycle_count       = 0;
		cycle_limit       = 0;
		for (int i = 0; i < NUM_TESTS; i++) begin
			cycle_limit += row_count[i] * 8 + 50;
		end
		@(posedge rstn);
		@(negedge clock);
		check_reset_state();
		for (int t = 0; t < NUM_TESTS; t++) begin
			test_errors   = errors;
			load_table(t);
			filtered_base = int'(filtered_count);
			forwarded     = 0;
			pulse_start(t);
			run_cycle     = 0;
			// Sparse downstream requests fill the buffer, enable drops until done
			while (!done) begin
				vertex_request <= !row_gaps[t] || (($urandom % 3) == 0);
				enabled        <= !row_toggle[t] || ((run_cycle % 16) < 12);
				run_cycle++;
				@(negedge clock);
			end
			enabled        <= 1'b1;
			vertex_request <= 1'b1;
			repeat (SETTLE_CYCLES) @(negedge clock);
			total = forwarded + int'(filtered_count) - filtered_base;
			assert (total == row_count[t]) else
				report_mismatch("forwarded plus filtered", row_count[t], total);
			assert (done) else report_mismatch("done", 1, 0);
			// Monitor results of the last falling edge are in by now
			@(posedge clock);
			if (errors != test_errors) begin
				failed_tests++;
			end
			$display("Test %0d first=%0d count=%0d forwarded=%0d filtered=%0d %s", t,
				row_first[t], row_count[t], forwarded, total - forwarded,
				(errors == test_errors) ? "ok" : "FAILED");
		end
		$display("Tests run: %0d, tests failed: %0d, errors: %0d", NUM_TESTS, failed_tests,
			errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic clock,
	output logic rstn
);

	localparam int HALF_PERIOD  = 5;
	localparam int RESET_CYCLES = 4;

	// Free-running 10 ns clock
	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	// Reset held for the first cycles, released on a falling edge
	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
	end

endmodule

`default_nettype wire
